// ==== src/cpc_settings.svh ====
/*
 * Shared widths, ROM chunk and page constants,
 * Multiface fetch and port addresses, hardware register shadow offsets
 */
`ifndef CPC_SETTINGS_SVH
`define CPC_SETTINGS_SVH

// Memory geometry
`define CPC_RAM_AW          23          // SDRAM byte address
`define CPC_CHUNK_AW        14          // 16 KB ROM chunk
`define CPC_PAGE_W          8           // Upper ROM page number
`define CPC_MF2_AW          13          // 8 KB Multiface RAM

// Region-and-page values, region bit on top
`define CPC_MF2_PAGE        9'h1FF
`define CPC_MALFORMED_PAGE  9'h1EE      // Spare page, never selected by the CPU

// Multiface fetch and switch addresses
`define CPC_MF2_NMI_ADDR    16'h0066
`define CPC_MF2_HIDE_ADDR   16'h0065
`define CPC_MF2_SWITCH_PORT 14'b1111_1110_1110_10   // FEE8h and FEEAh

// Shadow offsets inside Multiface RAM
`define CPC_SHADOW_PEN          13'h1FCF
`define CPC_SHADOW_BORDER       13'h1FDF
`define CPC_SHADOW_PALETTE_BASE 13'h1F90    // Plus pen 0..15
`define CPC_SHADOW_MODE         13'h1FEF
`define CPC_SHADOW_BANK         13'h1FFF
`define CPC_SHADOW_CRTC_SEL     13'h1CFF
`define CPC_SHADOW_CRTC_BASE    13'h1DB0    // Plus CRTC register 0..15
`define CPC_SHADOW_PPI          13'h17FF
`define CPC_SHADOW_ROMSEL       13'h1AAC

`endif

// ==== src/cpc_pkg.sv ====
/*
 * Packed bus and request types of the memory glue
 * CPU bus, CPU memory request, SDRAM request, download beat, configuration
 */
`include "cpc_settings.svh"

package cpc_pkg;

	// CPU bus as seen by the glue
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        io_wr;     // Levels, edges found downstream
		logic        io_rd;
		logic        m1;
	} cpu_bus_t;

	// CPU memory request, already mapped to SDRAM space
	typedef struct packed {
		logic                   rd;
		logic                   wr;
		logic [`CPC_RAM_AW-1:0] addr;
		logic [7:0]             wdata;
	} mem_req_t;

	// Request towards the SDRAM controller
	typedef struct packed {
		logic                   oe;
		logic                   we;
		logic [`CPC_RAM_AW-1:0] addr;
		logic                   bank;   // Follows the model
		logic [7:0]             din;
	} sdram_req_t;

	// One byte of a host download
	typedef struct packed {
		logic        wr;        // Strobe
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_beat_t;

	typedef struct packed {
		logic       model;      // 0 = 6128, 1 = 664
		logic [1:0] mf2_mode;   // 0 enabled, 1 hidden, 2/3 disabled
	} mf2_cfg_t;

endpackage

// ==== src/rom_page_decode.sv ====
/*
 * Expansion ROM target page from the two-character file extension
 * Hex page, ZZ for page 0, Z0 for a combined image with Multiface part
 */
`include "cpc_settings.svh"

module rom_page_decode (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_start,
	input  logic [15:0]       dl_ext,
	input  logic              chunk_done,
	output logic [`CPC_PAGE_W:0] page,
	output logic              combo
);

	logic [4:0] hi_digit;   // {valid, value}
	logic [4:0] lo_digit;

	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f"))
			return {1'b1, c[3:0] + 4'd9};
		else
			return 5'd0;
	endfunction

	always_comb begin
		hi_digit = hex_digit(dl_ext[15:8]);
		lo_digit = hex_digit(dl_ext[7:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page  <= '0;
			combo <= 1'b0;
		end else if (dl_start) begin
			combo <= 1'b0;
			if (dl_ext == "ZZ") begin
				page <= '0;                // Replaces the lower ROM
			end else if (dl_ext == "Z0") begin
				page  <= '0;
				combo <= 1'b1;
			end else if (hi_digit[4] && lo_digit[4]) begin
				page <= {1'b1, hi_digit[3:0], lo_digit[3:0]};
			end else begin
				page <= `CPC_MALFORMED_PAGE;
			end
		end else if (chunk_done && combo) begin
			// Following beats sit in chunk 1, so the sum lands on the Multiface page
			page  <= `CPC_MF2_PAGE - 9'd1;
			combo <= 1'b0;
		end
	end

endmodule

// ==== src/rom_loader.sv ====
/*
 * ROM download loader
 * Beat to boot write mapping, wait sequencing on mem_ce,
 * loaded upper ROM page map and latched model
 */
`include "cpc_settings.svh"

module rom_loader (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                mem_ce,
	input  cpc_pkg::dl_beat_t   dl,
	input  logic                dl_active,
	input  logic [7:0]          dl_index,
	input  logic [15:0]         dl_ext,
	input  cpc_pkg::mf2_cfg_t   cfg,
	output logic                dl_wait,
	output cpc_pkg::sdram_req_t boot_req,
	output logic [255:0]        rom_loaded,
	output logic                model
);

	localparam logic [255:0] DEFAULT_MAP = (256'd1 << 255) | (256'd1 << 7) | 256'd1;

	logic                   ext_reset;      // Outside reset, download not running
	logic                   dl_active_d;
	logic                   dl_start;
	logic                   accept;
	logic [10:0]            chunk;
	logic                   base_ok;
	logic                   write_done;
	logic                   chunk_done;
	logic                   boot_we;
	logic [`CPC_RAM_AW-1:0] boot_addr;
	logic                   boot_bank;
	logic [7:0]             boot_din;
	logic [`CPC_PAGE_W:0]   page;
	logic                   combo;

	assign ext_reset  = reset & ~dl_active;
	assign dl_start   = dl_active & ~dl_active_d & (dl_index != 8'd0);
	assign accept     = dl_active & dl.wr;
	assign chunk      = dl.addr[24:`CPC_CHUNK_AW];
	assign base_ok    = (chunk < 11'd8);
	assign write_done = mem_ce & boot_we & dl_wait;
	assign chunk_done = write_done & combo & (&boot_addr[`CPC_CHUNK_AW-1:0]);

	rom_page_decode u_page_decode (
		.clk_sys    (clk_sys),
		.reset      (ext_reset),
		.dl_start   (dl_start),
		.dl_ext     (dl_ext),
		.chunk_done (chunk_done),
		.page       (page),
		.combo      (combo)
	);

	////////////////////////////////////////
	// Wait level and write strobe
	always_ff @(posedge clk_sys) begin
		if (ext_reset) begin
			dl_active_d <= 1'b0;
			dl_wait     <= 1'b0;
			boot_we     <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (accept && (dl_index != 8'd0 || base_ok))
				dl_wait <= 1'b1;            // Base chunks past 7 are dropped
			if (mem_ce)
				boot_we <= dl_wait;
			if (write_done) begin
				boot_we <= 1'b0;
				dl_wait <= 1'b0;
			end
		end
	end

	// Beat payload and target
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			boot_din                       <= dl.data;
			boot_addr[`CPC_CHUNK_AW-1:0]   <= dl.addr[`CPC_CHUNK_AW-1:0];
			if (dl_index != 8'd0) begin
				boot_addr[`CPC_RAM_AW-1]   <= page[`CPC_PAGE_W];
				boot_addr[21:`CPC_CHUNK_AW] <= page[`CPC_PAGE_W-1:0] + dl.addr[21:`CPC_CHUNK_AW];
				boot_bank                  <= model;
			end else begin
				case (chunk[1:0])
					2'd0: boot_addr[22:`CPC_CHUNK_AW] <= 9'h000;   // OS
					2'd1: boot_addr[22:`CPC_CHUNK_AW] <= 9'h100;   // BASIC
					2'd2: boot_addr[22:`CPC_CHUNK_AW] <= 9'h107;   // AMSDOS
					default: boot_addr[22:`CPC_CHUNK_AW] <= `CPC_MF2_PAGE;
				endcase
				boot_bank <= chunk[2];
			end
		end
	end

	// Page map and model
	always_ff @(posedge clk_sys) begin
		if (write_done && boot_addr[`CPC_RAM_AW-1])
			rom_loaded[boot_addr[21:`CPC_CHUNK_AW]] <= 1'b1;
		if (reset) begin
			model <= cfg.model;
			// A first reset has no latched model yet and also loads the defaults
			if (model !== cfg.model)
				rom_loaded <= DEFAULT_MAP;
		end
	end

	assign boot_req = '{oe: 1'b0, we: boot_we, addr: boot_addr, bank: boot_bank, din: boot_din};

	// Host holds off while a write is pending
	a_beat_only_when_idle: assert property (@(posedge clk_sys) disable iff (ext_reset)
		accept |-> !dl_wait);

endmodule

// ==== src/mf2_shadow_map.sv ====
/*
 * Hardware register shadowing for Multiface Two
 * Gate array, CRTC, PPI and ROM select writes to shadow RAM offsets
 */
`include "cpc_settings.svh"

module mf2_shadow_map (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cpc_pkg::cpu_bus_t      bus,
	input  logic                   io_wr_rise,
	output logic [`CPC_MF2_AW-1:0] shadow_addr   // Zero when not shadowed
);

	logic [4:0] pen_index;
	logic [3:0] crtc_reg;
	logic       pen_sel_wr;
	logic       crtc_sel_wr;

	assign pen_sel_wr  = (bus.addr[15:8] == 8'h7F) && (bus.wdata[7:6] == 2'b00);
	assign crtc_sel_wr = (bus.addr[15:8] == 8'hBC);

	// Index registers, as the hardware sees them
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (io_wr_rise) begin
			if (pen_sel_wr)
				pen_index <= bus.wdata[4:0];
			if (crtc_sel_wr)
				crtc_reg <= bus.wdata[3:0];
		end
	end

	always_comb begin
		casez ({bus.addr[15:8], bus.wdata[7:6]})
			{8'h7F, 2'b00}: shadow_addr = `CPC_SHADOW_PEN;
			{8'h7F, 2'b01}: begin
				if (pen_index[4])
					shadow_addr = `CPC_SHADOW_BORDER;
				else
					shadow_addr = `CPC_SHADOW_PALETTE_BASE + {9'd0, pen_index[3:0]};
			end
			{8'h7F, 2'b10}: shadow_addr = `CPC_SHADOW_MODE;   // Mode and ROM enables
			{8'h7F, 2'b11}: shadow_addr = `CPC_SHADOW_BANK;   // RAM banking
			{8'hBC, 2'b??}: shadow_addr = `CPC_SHADOW_CRTC_SEL;
			{8'hBD, 2'b??}: shadow_addr = `CPC_SHADOW_CRTC_BASE + {9'd0, crtc_reg};
			{8'hF7, 2'b??}: shadow_addr = `CPC_SHADOW_PPI;    // 8255 control
			{8'hDF, 2'b??}: shadow_addr = `CPC_SHADOW_ROMSEL;
			default:        shadow_addr = '0;
		endcase
	end

endmodule

// ==== src/mf2_control.sv ====
/*
 * Multiface Two control
 * NMI capture, enable and hidden state, 8 KB private RAM and its port
 */
`include "cpc_settings.svh"

module mf2_control (
	input  logic              clk_sys,
	input  logic              reset,
	input  cpc_pkg::cpu_bus_t bus,
	input  logic              key_nmi,
	input  cpc_pkg::mf2_cfg_t cfg,
	input  cpc_pkg::mem_req_t cpu_mem,
	output logic              nmi,
	output logic              mf2_en,
	output logic              mf2_ram_sel,
	output logic              mf2_rom_sel,
	output logic [7:0]        mf2_rdata
);

	logic                   key_nmi_d;
	logic                   m1_d;
	logic                   io_wr_d;
	logic                   key_rise;
	logic                   m1_rise;
	logic                   io_wr_rise;
	logic                   switch_wr;
	logic                   shadow_wr;
	logic                   mf2_hidden;
	logic [`CPC_MF2_AW-1:0] shadow_addr;
	logic [`CPC_MF2_AW-1:0] ram_addr;
	logic [7:0]             ram_wdata;
	logic                   ram_we;
	logic [7:0]             mf2_ram [0:(1 << `CPC_MF2_AW)-1];

	always_ff @(posedge clk_sys) begin
		key_nmi_d <= key_nmi;
		m1_d      <= bus.m1;
		io_wr_d   <= bus.io_wr;
	end

	assign key_rise    = key_nmi & ~key_nmi_d;
	assign m1_rise     = bus.m1 & ~m1_d;
	assign io_wr_rise  = bus.io_wr & ~io_wr_d;
	assign switch_wr   = io_wr_rise & (bus.addr[15:2] == `CPC_MF2_SWITCH_PORT);
	assign shadow_wr   = io_wr_rise & ~switch_wr & (shadow_addr != '0);
	assign mf2_rom_sel = mf2_en & (bus.addr[15:13] == 3'b000);   // 0000h-1FFFh
	assign mf2_ram_sel = mf2_en & (bus.addr[15:13] == 3'b001);   // 2000h-3FFFh

	mf2_shadow_map u_shadow_map (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.io_wr_rise  (io_wr_rise),
		.shadow_addr (shadow_addr)
	);

	////////////////////////////////////////
	// Enable, hidden and NMI
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi        <= 1'b0;
			mf2_en     <= 1'b0;
			mf2_hidden <= (cfg.mf2_mode != 2'd0);
		end else begin
			if (key_rise && !mf2_en && !cfg.mf2_mode[1])
				nmi <= 1'b1;
			if (nmi && m1_rise && bus.addr == `CPC_MF2_NMI_ADDR) begin
				mf2_en     <= 1'b1;             // NMI vector fetched
				mf2_hidden <= 1'b0;
				nmi        <= 1'b0;
			end
			if (mf2_en && m1_rise && bus.addr == `CPC_MF2_HIDE_ADDR)
				mf2_hidden <= 1'b1;
			if (switch_wr) begin
				mf2_en <= ~bus.addr[1] & ~mf2_hidden;
				if (!bus.addr[1] && !mf2_hidden)
					nmi <= 1'b0;                // Already running, pending NMI dropped
			end
		end
	end

	////////////////////////////////////////
	// RAM port, shadow writes take priority
	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= shadow_wr | (cpu_mem.wr & mf2_ram_sel);
	end

	always_ff @(posedge clk_sys) begin
		if (shadow_wr) begin
			ram_addr  <= shadow_addr;
			ram_wdata <= bus.wdata;
		end else begin
			ram_addr  <= cpu_mem.addr[`CPC_MF2_AW-1:0];
			ram_wdata <= cpu_mem.wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mf2_ram[ram_addr] <= ram_wdata;
			mf2_rdata         <= ram_wdata;   // Write-through
		end else begin
			mf2_rdata <= mf2_ram[ram_addr];
		end
	end

	a_nmi_excl_en: assert property (@(posedge clk_sys) disable iff (reset) !(nmi && mf2_en));

endmodule

// ==== src/cpc_mem_glue.sv ====
/*
 * Memory-side glue of the CPC core
 * ROM loader, Multiface Two, SDRAM request mux and read masking
 */
`include "cpc_settings.svh"

module cpc_mem_glue (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                mem_ce,
	input  cpc_pkg::dl_beat_t   dl,
	input  logic                dl_active,
	input  logic [7:0]          dl_index,
	input  logic [15:0]         dl_ext,
	output logic                dl_wait,
	input  cpc_pkg::mf2_cfg_t   cfg,
	input  cpc_pkg::cpu_bus_t   bus,
	input  cpc_pkg::mem_req_t   cpu_mem,
	input  logic                key_nmi,
	output logic                nmi,
	output logic                mf2_en,
	output logic [7:0]          cpu_rdata,
	output cpc_pkg::sdram_req_t sdram_req,
	input  logic [7:0]          sdram_rdata
);

	logic                sys_reset;     // CPU held during downloads
	cpc_pkg::sdram_req_t boot_req;
	logic [255:0]        rom_loaded;
	logic                model;
	logic                mf2_ram_sel;
	logic                mf2_rom_sel;
	logic [7:0]          mf2_rdata;
	logic [7:0]          rom_mask;

	assign sys_reset = reset | dl_active;

	rom_loader u_loader (
		.clk_sys    (clk_sys),
		.reset      (sys_reset),
		.mem_ce     (mem_ce),
		.dl         (dl),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_ext     (dl_ext),
		.cfg        (cfg),
		.dl_wait    (dl_wait),
		.boot_req   (boot_req),
		.rom_loaded (rom_loaded),
		.model      (model)
	);

	mf2_control u_mf2 (
		.clk_sys     (clk_sys),
		.reset       (sys_reset),
		.bus         (bus),
		.key_nmi     (key_nmi),
		.cfg         (cfg),
		.cpu_mem     (cpu_mem),
		.nmi         (nmi),
		.mf2_en      (mf2_en),
		.mf2_ram_sel (mf2_ram_sel),
		.mf2_rom_sel (mf2_rom_sel),
		.mf2_rdata   (mf2_rdata)
	);

	////////////////////////////////////////
	// SDRAM port owner
	always_comb begin
		if (sys_reset) begin
			sdram_req = boot_req;
		end else begin
			sdram_req.oe   = cpu_mem.rd & ~mf2_ram_sel;
			sdram_req.we   = cpu_mem.wr & ~mf2_ram_sel & ~mf2_rom_sel;   // Multiface ROM is read only
			sdram_req.addr = mf2_rom_sel ? {`CPC_MF2_PAGE, bus.addr[`CPC_CHUNK_AW-1:0]}
			                             : cpu_mem.addr;
			sdram_req.bank = model;
			sdram_req.din  = cpu_mem.wdata;
		end
	end

	// Unloaded upper ROM pages float high
	assign rom_mask  = (!cpu_mem.addr[`CPC_RAM_AW-1] || rom_loaded[cpu_mem.addr[21:`CPC_CHUNK_AW]])
	                   ? 8'h00 : 8'hFF;
	assign cpu_rdata = (mf2_ram_sel ? mf2_rdata : sdram_rdata) | rom_mask;

endmodule

// ==== dv/tb_vectors.svh ====
/*
 * Stimulus rows for the memory glue testbench
 * Row kinds, row type and the table of downloads, CPU and Multiface accesses
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [3:0] K_DLSTART = 4'd0;   // d = index, a = extension
localparam logic [3:0] K_DLEND   = 4'd1;
localparam logic [3:0] K_BEAT    = 4'd2;   // Expect boot write at exp_addr
localparam logic [3:0] K_DROP    = 4'd3;   // Expect no write
localparam logic [3:0] K_READ    = 4'd4;   // d = SDRAM data
localparam logic [3:0] K_KEY     = 4'd5;   // exp_data = {nmi, mf2_en}
localparam logic [3:0] K_M1      = 4'd6;
localparam logic [3:0] K_MFRW    = 4'd7;   // Multiface RAM round trip
localparam logic [3:0] K_MFRD    = 4'd8;
localparam logic [3:0] K_IOWR    = 4'd9;
localparam logic [3:0] K_RESET   = 4'd10;  // d = {model, mf2_mode}

typedef struct packed {
	logic [3:0]  kind;
	logic        rnd;       // Data byte from the LFSR
	logic [24:0] a;
	logic [7:0]  d;
	logic [22:0] exp_addr;
	logic        exp_bank;
	logic [7:0]  exp_data;
} vec_t;

localparam int NUM_VECTORS = 41;

localparam vec_t VECTORS [0:NUM_VECTORS-1] = '{
	'{K_DLSTART, 1'b0, 25'h0000000, 8'h00, 23'h000000, 1'b0, 8'h00},   // Base ROM
	'{K_BEAT,    1'b1, 25'h0000010, 8'h00, 23'h000010, 1'b0, 8'h00},
	'{K_BEAT,    1'b1, 25'h0004020, 8'h00, 23'h400020, 1'b0, 8'h00},
	'{K_BEAT,    1'b1, 25'h0008030, 8'h00, 23'h41C030, 1'b0, 8'h00},
	'{K_BEAT,    1'b1, 25'h000C040, 8'h00, 23'h7FC040, 1'b0, 8'h00},
	'{K_BEAT,    1'b1, 25'h0010050, 8'h00, 23'h000050, 1'b1, 8'h00},
	'{K_BEAT,    1'b1, 25'h0014060, 8'h00, 23'h400060, 1'b1, 8'h00},
	'{K_BEAT,    1'b1, 25'h0018070, 8'h00, 23'h41C070, 1'b1, 8'h00},
	'{K_BEAT,    1'b1, 25'h001FFFF, 8'h00, 23'h7FFFFF, 1'b1, 8'h00},
	'{K_DROP,    1'b1, 25'h0020000, 8'h00, 23'h000000, 1'b0, 8'h00},   // Chunk 8
	'{K_DLEND,   1'b0, 25'h0000000, 8'h00, 23'h000000, 1'b0, 8'h00},
	'{K_DLSTART, 1'b0, 25'h0003041, 8'h01, 23'h000000, 1'b0, 8'h00},   // "0A"
	'{K_BEAT,    1'b1, 25'h0000123, 8'h00, 23'h428123, 1'b0, 8'h00},
	'{K_BEAT,    1'b1, 25'h0003FFF, 8'h00, 23'h42BFFF, 1'b0, 8'h00},
	'{K_DLEND,   1'b0, 25'h0000000, 8'h00, 23'h000000, 1'b0, 8'h00},
	'{K_READ,    1'b0, 25'h0428000, 8'h5C, 23'h000000, 1'b0, 8'h5C},
	'{K_READ,    1'b0, 25'h0480000, 8'h5C, 23'h000000, 1'b0, 8'hFF},   // Page 20h unloaded
	'{K_DLSTART, 1'b0, 25'h0005A30, 8'h02, 23'h000000, 1'b0, 8'h00},   // "Z0"
	'{K_BEAT,    1'b1, 25'h0003FFF, 8'h00, 23'h003FFF, 1'b0, 8'h00},
	'{K_BEAT,    1'b1, 25'h0004000, 8'h00, 23'h7FC000, 1'b0, 8'h00},
	'{K_DLEND,   1'b0, 25'h0000000, 8'h00, 23'h000000, 1'b0, 8'h00},
	'{K_RESET,   1'b0, 25'h0000000, 8'h04, 23'h000000, 1'b0, 8'h00},   // Model 664
	'{K_READ,    1'b0, 25'h0428000, 8'h5C, 23'h000000, 1'b1, 8'hFF},
	'{K_READ,    1'b0, 25'h0400000, 8'h11, 23'h000000, 1'b1, 8'h11},
	'{K_READ,    1'b0, 25'h041C000, 8'h22, 23'h000000, 1'b1, 8'h22},
	'{K_READ,    1'b0, 25'h07FC000, 8'h33, 23'h000000, 1'b1, 8'h33},
	'{K_KEY,     1'b0, 25'h0000000, 8'h00, 23'h000000, 1'b0, 8'h02},
	'{K_M1,      1'b0, 25'h0000066, 8'h00, 23'h000066, 1'b0, 8'h01},
	'{K_MFRW,    1'b1, 25'h0002345, 8'h00, 23'h000000, 1'b0, 8'h00},
	'{K_M1,      1'b0, 25'h0001234, 8'h00, 23'h7FD234, 1'b0, 8'h01},
	'{K_IOWR,    1'b0, 25'h0007F00, 8'h03, 23'h000000, 1'b0, 8'h01},   // Pen 3
	'{K_IOWR,    1'b0, 25'h0007F00, 8'h4B, 23'h000000, 1'b0, 8'h01},
	'{K_MFRD,    1'b0, 25'h0003F93, 8'h00, 23'h000000, 1'b0, 8'h4B},
	'{K_IOWR,    1'b0, 25'h000BC00, 8'h0C, 23'h000000, 1'b0, 8'h01},   // CRTC R12
	'{K_IOWR,    1'b0, 25'h000BD00, 8'h30, 23'h000000, 1'b0, 8'h01},
	'{K_MFRD,    1'b0, 25'h0003DBC, 8'h00, 23'h000000, 1'b0, 8'h30},
	'{K_M1,      1'b0, 25'h0000065, 8'h00, 23'h7FC065, 1'b0, 8'h01},
	'{K_IOWR,    1'b0, 25'h000FEEA, 8'h00, 23'h000000, 1'b0, 8'h00},
	'{K_IOWR,    1'b0, 25'h000FEE8, 8'h00, 23'h000000, 1'b0, 8'h00},   // Hidden, stays off
	'{K_RESET,   1'b0, 25'h0000000, 8'h06, 23'h000000, 1'b0, 8'h00},   // Multiface disabled
	'{K_KEY,     1'b0, 25'h0000000, 8'h00, 23'h000000, 1'b0, 8'h00}
};

`endif

// ==== dv/tb_cpc_mem_glue.sv ====
/*
 * Testbench for the memory glue
 * Clock, reset, mem_ce strobe, LFSR, checks and the row apply loop
 */
module tb_cpc_mem_glue;
	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_vectors.svh"

	logic                clk_sys;
	logic                reset;
	logic                mem_ce;
	cpc_pkg::dl_beat_t   dl;
	logic                dl_active;
	logic [7:0]          dl_index;
	logic [15:0]         dl_ext;
	logic                dl_wait;
	cpc_pkg::mf2_cfg_t   cfg;
	cpc_pkg::cpu_bus_t   bus;
	cpc_pkg::mem_req_t   cpu_mem;
	logic                key_nmi;
	logic                nmi;
	logic                mf2_en;
	logic [7:0]          cpu_rdata;
	cpc_pkg::sdram_req_t sdram_req;
	logic [7:0]          sdram_rdata;
	logic [31:0]         lfsr_state;
	logic [1:0]          ce_count;

	cpc_mem_glue DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		ce_count <= ce_count + 2'd1;
		mem_ce   <= (ce_count == 2'd3);    // One slot in four
	end

	////////////////////////////////////////
	// Helpers
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run("Stopping at the first mismatch");
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [7:0] next_rand_byte();
		logic       fb;
		logic [7:0] b;
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			b          = {b[6:0], fb};
		end
		return b;
	endfunction

	task automatic drive_idle();
		@(posedge clk_sys);
		dl          <= '0;
		bus         <= '{addr: 16'hC000, wdata: 8'h00, io_wr: 1'b0, io_rd: 1'b0, m1: 1'b0};
		cpu_mem     <= '0;
		key_nmi     <= 1'b0;
		sdram_rdata <= 8'h00;
	endtask

	task automatic wait_boot_write();
		int n;
		for (n = 0; n < 64; n++) begin
			@(negedge clk_sys);
			if (sdram_req.we)
				break;
		end
		if (n == 64)
			stop_run("Timed out waiting for the boot write strobe");
	endtask

	task automatic wait_dl_wait_low();
		int n;
		for (n = 0; n < 64; n++) begin
			@(negedge clk_sys);
			if (!dl_wait)
				break;
		end
		if (n == 64)
			stop_run("Timed out waiting for dl_wait to fall");
	endtask

	task automatic mf_read(input logic [24:0] a, input logic [7:0] exp);
		@(posedge clk_sys);
		bus.addr <= a[15:0];
		cpu_mem  <= '{rd: 1'b1, wr: 1'b0, addr: a[22:0], wdata: 8'h00};
		repeat (3) @(posedge clk_sys);     // Address then data register
		@(negedge clk_sys);
		check_value(cpu_rdata, exp, "Multiface RAM read");
		check_value(sdram_req.oe, 1'b0, "SDRAM read during Multiface RAM read");
		drive_idle();
	endtask

	task automatic apply_row(input vec_t v);
		logic [7:0] data;
		data = v.d;
		if (v.rnd)
			data = next_rand_byte();
		case (v.kind)
			K_DLSTART: begin
				@(posedge clk_sys);
				dl_index  <= v.d;
				dl_ext    <= v.a[15:0];
				dl_active <= 1'b1;
				repeat (2) @(posedge clk_sys);
			end
			K_DLEND: begin
				@(posedge clk_sys);
				dl_active <= 1'b0;
				repeat (2) @(posedge clk_sys);
			end
			K_BEAT, K_DROP: begin
				@(posedge clk_sys);
				dl <= '{wr: 1'b1, addr: v.a, data: data};
				@(posedge clk_sys);
				dl.wr <= 1'b0;
				if (v.kind == K_BEAT) begin
					wait_boot_write();
					check_value(sdram_req.addr, v.exp_addr, "boot write address");
					check_value(sdram_req.bank, v.exp_bank, "boot write bank");
					check_value(sdram_req.din, data, "boot write data");
					wait_dl_wait_low();
				end else begin
					repeat (12) begin
						@(negedge clk_sys);
						check_value(dl_wait, 1'b0, "dl_wait on dropped beat");
						check_value(sdram_req.we, 1'b0, "write strobe on dropped beat");
					end
				end
			end
			K_READ: begin
				@(posedge clk_sys);
				bus.addr    <= v.a[15:0];
				cpu_mem     <= '{rd: 1'b1, wr: 1'b0, addr: v.a[22:0], wdata: 8'h00};
				sdram_rdata <= data;
				@(negedge clk_sys);
				check_value(cpu_rdata, v.exp_data, "CPU read data");
				check_value(sdram_req.oe, 1'b1, "SDRAM read enable");
				check_value(sdram_req.bank, v.exp_bank, "SDRAM bank");
				drive_idle();
			end
			K_KEY: begin
				@(posedge clk_sys);
				key_nmi <= 1'b1;
				@(posedge clk_sys);
				key_nmi <= 1'b0;
				repeat (2) @(posedge clk_sys);
				@(negedge clk_sys);
				check_value({nmi, mf2_en}, v.exp_data[1:0], "nmi and mf2_en after key");
			end
			K_M1: begin
				@(posedge clk_sys);
				bus.addr <= v.a[15:0];
				bus.m1   <= 1'b1;
				cpu_mem  <= '{rd: 1'b1, wr: 1'b0, addr: v.a[22:0], wdata: 8'h00};
				@(negedge clk_sys);
				check_value(sdram_req.addr, v.exp_addr, "fetch address");
				drive_idle();
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_value({nmi, mf2_en}, v.exp_data[1:0], "nmi and mf2_en after fetch");
			end
			K_MFRW: begin
				@(posedge clk_sys);
				bus.addr <= v.a[15:0];
				cpu_mem  <= '{rd: 1'b0, wr: 1'b1, addr: v.a[22:0], wdata: data};
				@(negedge clk_sys);
				check_value(sdram_req.we, 1'b0, "SDRAM write during Multiface RAM write");
				drive_idle();
				mf_read(v.a, data);
			end
			K_MFRD: mf_read(v.a, v.exp_data);
			K_IOWR: begin
				@(posedge clk_sys);
				bus.addr  <= v.a[15:0];
				bus.wdata <= data;
				bus.io_wr <= 1'b1;
				drive_idle();
				repeat (2) @(posedge clk_sys);
				@(negedge clk_sys);
				check_value({nmi, mf2_en}, v.exp_data[1:0], "nmi and mf2_en after I/O write");
			end
			K_RESET: begin
				@(posedge clk_sys);
				cfg   <= v.d[2:0];
				reset <= 1'b1;
				repeat (5) @(posedge clk_sys);
				reset <= 1'b0;
				repeat (2) @(posedge clk_sys);
			end
			default: stop_run("Unknown row kind in the stimulus table");
		endcase
	endtask

	////////////////////////////////////////
	// Main sequence
	initial begin
		reset       = 1'b1;
		ce_count    = 2'd0;
		mem_ce      = 1'b0;
		dl          = '0;
		dl_active   = 1'b0;
		dl_index    = 8'h00;
		dl_ext      = 16'h0000;
		cfg         = '{model: 1'b0, mf2_mode: 2'd0};
		bus         = '{addr: 16'hC000, wdata: 8'h00, io_wr: 1'b0, io_rd: 1'b0, m1: 1'b0};
		cpu_mem     = '0;
		key_nmi     = 1'b0;
		sdram_rdata = 8'h00;
		lfsr_state  = 32'h7146f1ce;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < NUM_VECTORS; i++)
			apply_row(VECTORS[i]);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
+incdir+dv
src/cpc_pkg.sv
src/rom_page_decode.sv
src/rom_loader.sv
src/mf2_shadow_map.sv
src/mf2_control.sv
src/cpc_mem_glue.sv
dv/tb_cpc_mem_glue.sv
